// ==== src/alu_pkg.sv ====
/*
 * Shared widths, comparator indices, ALU and shifter opcodes, and the
 * co-processor timeout constant. Imported by every RTL module of the ALU.
 */
package alu_pkg;

    // ----------------------------------------
    // data path widths
    // ----------------------------------------
    localparam int XLEN    = 32; // integer data width
    localparam int SHAMT_W = 5;  // shift amount bits, log2(XLEN)

    // comparator status bit positions
    localparam int CMP_EQUAL = 0; // rs1 == rs2
    localparam int CMP_LESS  = 1; // rs1 < rs2, signed or unsigned

    // co-processor watchdog counter width
    // exception once the top bit is set (32 cycles) and op still open
    localparam int CP_TIMEOUT_W = 6;

    // ----------------------------------------
    // opcodes
    // ----------------------------------------
    // bit 0 drives the adder's subtract select, so SUB and SLT are the
    // arithmetic ops with it set; XOR/AND never read the sum
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000, // opa + opb
        ALU_SUB  = 3'b001, // opa - opb
        ALU_CP   = 3'b010, // co-processor result
        ALU_SLT  = 3'b011, // set if opa < opb
        ALU_MOVB = 3'b100, // pass operand b
        ALU_XOR  = 3'b101, // rs1 ^ opb
        ALU_OR   = 3'b110, // rs1 | opb
        ALU_AND  = 3'b111  // rs1 & opb
    } alu_op_e;

    // bit 1 marks the arithmetic (sign filling) variant
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00, // left, zero fill
        SHIFT_SRL = 2'b01, // right, zero fill
        SHIFT_SRA = 2'b11  // right, sign fill
    } shift_op_e;

endpackage

// ==== src/alu_prefix_adder.sv ====
/*
 * 33-bit sign/zero extended adder-subtracter for the ALU and address path.
 * Carries come from a five-level parallel-prefix tree over the carry-in and
 * operand bits 0..30, bit 31 gets a separate final carry stage.
 */
module alu_prefix_adder import alu_pkg::*; (
    input  logic [XLEN-1:0] opa_i,      // operand a
    input  logic [XLEN-1:0] opb_i,      // operand b
    input  logic            sub_i,      // 1 = opa - opb
    input  logic            unsigned_i, // zero-extend instead of sign-extend
    output logic [XLEN:0]   sum_o       // bit XLEN is the less-than flag on sub
);

    logic [XLEN:0]   opa_v;          // extended operand a
    logic [XLEN:0]   opb_x;          // extended operand b
    logic [XLEN:0]   opb_v;          // operand b, inverted on subtract
    logic [XLEN:0]   p;              // half sum, doubles as propagate
    logic [XLEN-1:0] g;              // generate
    logic [XLEN-1:0] g_lvl [0:5];    // group generate per tree level
    logic [XLEN-1:0] p_lvl [0:4];    // group propagate, last level not needed
    logic [XLEN:0]   c;              // carry into each sum bit

    // ----------------------------------------
    // operand preparation
    // ----------------------------------------
    assign opa_v = {opa_i[XLEN-1] & ~unsigned_i, opa_i}; // optional sign bit
    assign opb_x = {opb_i[XLEN-1] & ~unsigned_i, opb_i};
    assign opb_v = sub_i ? ~opb_x : opb_x;               // two's complement with cin

    assign p = opa_v ^ opb_v;
    assign g = opa_v[XLEN-1:0] & opb_v[XLEN-1:0];

    // position 0 is the carry-in, position k+1 is operand bit k
    assign g_lvl[0] = {g[XLEN-2:0], sub_i};
    assign p_lvl[0] = {p[XLEN-2:0], 1'b0};  // carry-in never propagates

    // ----------------------------------------
    // prefix tree, distances 1 2 4 8 16
    // ----------------------------------------
    for (genvar lvl = 1; lvl <= 5; lvl++) begin : g_level
        for (genvar i = 0; i < XLEN; i++) begin : g_bit
            if (i >= 2 ** (lvl - 1)) begin : g_merge
                assign g_lvl[lvl][i] = g_lvl[lvl-1][i] |
                                       (p_lvl[lvl-1][i] & g_lvl[lvl-1][i - 2 ** (lvl - 1)]);
                if (lvl < 5) begin : g_prop
                    assign p_lvl[lvl][i] = p_lvl[lvl-1][i] & p_lvl[lvl-1][i - 2 ** (lvl - 1)];
                end
            end else begin : g_pass
                assign g_lvl[lvl][i] = g_lvl[lvl-1][i]; // group already complete
                if (lvl < 5) begin : g_prop
                    assign p_lvl[lvl][i] = p_lvl[lvl-1][i];
                end
            end
        end
    end

    // carries into bits 0..31 straight out of the tree
    assign c[XLEN-1:0] = g_lvl[5];

    // final carry stage into the extension bit
    assign c[XLEN] = g[XLEN-1] | (p[XLEN-1] & c[XLEN-1]);

    assign sum_o = p ^ c; // sum bits

endmodule

// ==== src/alu_datapath.sv ====
/*
 * Combinational ALU data path: branch comparator, operand selection, the
 * prefix adder and the result multiplexer. The co-processor result enters
 * through cp_res_i and operand b leaves through opb_o for the shifter.
 */
module alu_datapath import alu_pkg::*; (
    input  alu_op_e         alu_op_i,   // operation select
    input  logic            unsigned_i, // unsigned compare / slt
    input  logic            opa_pc_i,   // operand a = pc
    input  logic            opb_imm_i,  // operand b = immediate
    input  logic [XLEN-1:0] rs1_i,      // register source 1
    input  logic [XLEN-1:0] rs2_i,      // register source 2
    input  logic [XLEN-1:0] pc_i,       // current pc
    input  logic [XLEN-1:0] imm_i,      // immediate
    input  logic [XLEN-1:0] cp_res_i,   // co-processor result
    output logic [1:0]      cmp_o,      // comparator status
    output logic [XLEN-1:0] add_o,      // address result
    output logic [XLEN-1:0] res_o,      // ALU result
    output logic [XLEN-1:0] opb_o       // selected operand b
);

    logic [XLEN:0]   cmp_rs1;   // extended compare inputs
    logic [XLEN:0]   cmp_rs2;
    logic [XLEN-1:0] opa;       // selected operand a
    logic [XLEN-1:0] opb;       // selected operand b
    logic [XLEN:0]   sum;       // adder result incl. less-than bit

    // ----------------------------------------
    // branch comparator
    // ----------------------------------------
    assign cmp_rs1 = {rs1_i[XLEN-1] & ~unsigned_i, rs1_i}; // sign bit only when signed
    assign cmp_rs2 = {rs2_i[XLEN-1] & ~unsigned_i, rs2_i};

    assign cmp_o[CMP_EQUAL] = (rs1_i == rs2_i);
    assign cmp_o[CMP_LESS]  = ($signed(cmp_rs1) < $signed(cmp_rs2)); // 33-bit compare

    // operand muxes
    assign opa   = opa_pc_i  ? pc_i  : rs1_i;
    assign opb   = opb_imm_i ? imm_i : rs2_i;
    assign opb_o = opb; // shift amount source

    // ----------------------------------------
    // adder, bit 0 of the opcode selects sub
    // ----------------------------------------
    alu_prefix_adder alu_prefix_adder_inst (
        .opa_i      (opa),
        .opb_i      (opb),
        .sub_i      (alu_op_i[0]),
        .unsigned_i (unsigned_i),
        .sum_o      (sum)
    );

    assign add_o = sum[XLEN-1:0]; // address path

    // ----------------------------------------
    // result select
    // ----------------------------------------
    always_comb begin : result_mux
        case (alu_op_i)
            ALU_ADD:  res_o = sum[XLEN-1:0];
            ALU_SUB:  res_o = sum[XLEN-1:0];
            ALU_SLT:  res_o = {{(XLEN-1){1'b0}}, sum[XLEN]}; // less-than flag
            ALU_MOVB: res_o = opb;
            ALU_XOR:  res_o = rs1_i ^ opb;
            ALU_OR:   res_o = rs1_i | opb;
            ALU_AND:  res_o = rs1_i & opb;
            ALU_CP:   res_o = cp_res_i;  // multi-cycle unit
            default:  res_o = sum[XLEN-1:0];
        endcase
    end : result_mux

endmodule

// ==== src/alu_shifter.sv ====
/*
 * Bit-serial shift co-processor. A start pulse loads rs1 and the amount,
 * then one bit is shifted per cycle. valid_o pulses one cycle before res_o
 * holds the result. Abort drops the running operation without a valid.
 */
module alu_shifter import alu_pkg::*; (
    input  logic               clk_i,      // clock, rising edge
    input  logic               rstn_i,     // async reset, active low
    input  logic               start_i,    // one-cycle trigger
    input  logic               abort_i,    // drop running op
    input  shift_op_e          shift_op_i, // shift type
    input  logic [XLEN-1:0]    rs1_i,      // data to shift
    input  logic [SHAMT_W-1:0] shamt_i,    // shift amount
    output logic [XLEN-1:0]    res_o,      // result register
    output logic               valid_o     // done pulse
);

    logic               busy;      // operation in progress
    logic [SHAMT_W-1:0] cnt;       // shifts still to do
    logic [XLEN-1:0]    data;      // working register
    logic [XLEN-1:0]    data_nxt;  // data after one more bit
    shift_op_e          op_q;      // latched shift type

    // ----------------------------------------
    // control and result
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin : shifter_ctrl
        if (!rstn_i) begin
            busy  <= 1'b0;
            cnt   <= '0;
            res_o <= '0;
        end else begin
            if (!busy) begin
                if (start_i) begin      // triggers while busy are dropped
                    busy  <= 1'b1;
                    cnt   <= shamt_i;
                    res_o <= '0;        // stale result hidden during op
                end
            end else if (abort_i) begin
                busy <= 1'b0;           // abandon, no valid
            end else if (cnt == '0) begin
                busy  <= 1'b0;
                res_o <= data;          // visible the cycle after valid
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end : shifter_ctrl

    // one bit per step
    always_comb begin : shift_step
        case (op_q)
            SHIFT_SLL: data_nxt = {data[XLEN-2:0], 1'b0};
            SHIFT_SRL: data_nxt = {1'b0, data[XLEN-1:1]};
            SHIFT_SRA: data_nxt = {data[XLEN-1], data[XLEN-1:1]}; // sign fill
            default:   data_nxt = {1'b0, data[XLEN-1:1]};
        endcase
    end : shift_step

    // working data path
    always_ff @(posedge clk_i) begin : shifter_data
        if (!busy && start_i) begin
            data <= rs1_i;
            op_q <= shift_op_i;
        end else if (busy && (cnt != '0)) begin
            data <= data_nxt;
        end
    end : shifter_data

    assign valid_o = busy & (cnt == '0); // last shift done

endmodule

// ==== src/alu_cp_unit.sv ====
/*
 * Co-processor unit: run/finish monitor with timeout exception around the
 * iterative shifter. Trap aborts the running operation, an operation still
 * open 32 cycles into its run raises exc_o.
 */
module alu_cp_unit import alu_pkg::*; (
    input  logic            clk_i,      // clock, rising edge
    input  logic            rstn_i,     // async reset, active low
    input  logic            cp_trig_i,  // start pulse
    input  logic            trap_i,     // abort level
    input  shift_op_e       shift_op_i, // shift type
    input  logic [XLEN-1:0] rs1_i,      // data to shift
    input  logic [XLEN-1:0] opb_i,      // operand b, low bits = amount
    output logic [XLEN-1:0] cp_res_o,   // co-processor result
    output logic            cp_done_o,  // done pulse
    output logic            exc_o       // timeout exception
);

    logic                    run;      // op being monitored
    logic                    fin;      // valid seen last cycle
    logic                    exc;      // registered exception
    logic [CP_TIMEOUT_W-1:0] cnt;      // timeout counter
    logic                    start;    // accepted trigger
    logic                    abort;    // trap during run
    logic                    valid;    // shifter done

    // ----------------------------------------
    // monitor
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin : cp_monitor
        if (!rstn_i) begin
            run <= 1'b0;
            fin <= 1'b0;
            exc <= 1'b0;
            cnt <= '0;
        end else begin
            exc <= run & cnt[CP_TIMEOUT_W-1] & ~fin; // too slow
            fin <= valid;
            if (!run) begin
                cnt <= '0;                // idle, hold at zero
                run <= start;
            end else begin
                cnt <= cnt + 1'b1;
                if (fin || trap_i) begin  // done or aborted
                    run <= 1'b0;
                end
            end
        end
    end : cp_monitor

    assign start = cp_trig_i & ~run; // one op in flight
    assign abort = trap_i & run;

    alu_shifter alu_shifter_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (start),
        .abort_i    (abort),
        .shift_op_i (shift_op_i),
        .rs1_i      (rs1_i),
        .shamt_i    (opb_i[SHAMT_W-1:0]), // amount slice
        .res_o      (cp_res_o),
        .valid_o    (valid)
    );

    assign cp_done_o = valid;
    assign exc_o     = exc;

endmodule

// ==== src/alu_top.sv ====
/*
 * ALU top level. Connects the combinational data path to the shifter
 * co-processor unit. Operand b feeds the shift amount and the
 * co-processor result returns into the result multiplexer.
 */
module alu_top import alu_pkg::*; (
    input  logic            clk_i,      // clock, rising edge
    input  logic            rstn_i,     // async reset, active low
    input  alu_op_e         alu_op_i,   // operation select
    input  shift_op_e       shift_op_i, // shift type
    input  logic            unsigned_i, // unsigned compare / slt
    input  logic            opa_pc_i,   // operand a = pc
    input  logic            opb_imm_i,  // operand b = immediate
    input  logic            cp_trig_i,  // co-processor start pulse
    input  logic            trap_i,     // abort level
    input  logic [XLEN-1:0] rs1_i,      // register source 1
    input  logic [XLEN-1:0] rs2_i,      // register source 2
    input  logic [XLEN-1:0] pc_i,       // current pc
    input  logic [XLEN-1:0] imm_i,      // immediate
    output logic [1:0]      cmp_o,      // comparator status
    output logic [XLEN-1:0] res_o,      // ALU result
    output logic [XLEN-1:0] add_o,      // address result
    output logic            exc_o,      // co-processor timeout
    output logic            cp_done_o   // co-processor done pulse
);

    logic [XLEN-1:0] opb;     // selected operand b
    logic [XLEN-1:0] cp_res;  // shifter result

    alu_datapath alu_datapath_inst (
        .alu_op_i   (alu_op_i),
        .unsigned_i (unsigned_i),
        .opa_pc_i   (opa_pc_i),
        .opb_imm_i  (opb_imm_i),
        .rs1_i      (rs1_i),
        .rs2_i      (rs2_i),
        .pc_i       (pc_i),
        .imm_i      (imm_i),
        .cp_res_i   (cp_res),
        .cmp_o      (cmp_o),
        .add_o      (add_o),
        .res_o      (res_o),
        .opb_o      (opb)
    );

    alu_cp_unit alu_cp_unit_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .cp_trig_i  (cp_trig_i),
        .trap_i     (trap_i),
        .shift_op_i (shift_op_i),
        .rs1_i      (rs1_i),
        .opb_i      (opb),
        .cp_res_o   (cp_res),
        .cp_done_o  (cp_done_o),
        .exc_o      (exc_o)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source. 40 ns clock, active low reset
 * held for the first five rising edges.
 */
module tb_clock_gen (
    output logic clk_o,   // free running clock
    output logic rstn_o   // active low reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20; // ns
    localparam int RESET_CYCLES = 5;
    localparam int RELEASE_DLY  = 2;  // release off the edge

    initial begin : clock_source
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end : clock_source

    initial begin : reset_source
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #RELEASE_DLY rstn_o = 1'b1;
    end : reset_source

endmodule

// ==== dv/alu_assertions.sv ====
/*
 * Concurrent checks on the co-processor done pulse and timeout exception.
 * Bound into alu_cp_unit at the bottom of this file.
 */
module alu_assertions (
    input logic clk_i,      // unit clock
    input logic rstn_i,     // unit reset
    input logic run_i,      // monitor run flag
    input logic cp_done_i,  // done pulse
    input logic exc_i       // timeout exception
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // done pulse shape
    // ----------------------------------------
    done_one_cycle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cp_done_i |=> !cp_done_i)
        else $error("cp_done_o high for more than one cycle");

    done_needs_run: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cp_done_i |-> run_i)
        else $error("cp_done_o pulsed while the unit was idle");

    // no stimulus here runs long enough to time out
    exc_stays_low: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !exc_i)
        else $error("exc_o raised during a legal operation");

endmodule

bind alu_cp_unit alu_assertions alu_assertions_inst (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .run_i     (run),
    .cp_done_i (cp_done_o),
    .exc_i     (exc_o)
);

// ==== dv/alu_tb.sv ====
/*
 * Random testbench for alu_top. Inputs change 2 ns after the rising edge,
 * outputs are sampled at the falling edge and compared with a behavioral
 * model of the comparator, the ALU ops and the shifter.
 */
module alu_tb import alu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int N_CMP      = 200;
    localparam int N_ALU      = 50;   // 7 ops x 4 mux settings each
    localparam int N_SHIFT    = 60;
    localparam int N_TRAP     = 4;
    localparam int DONE_WAIT  = 40;   // cycles allowed for a done pulse
    localparam int WATCHDOG_CYCLES = 10 + N_CMP + N_ALU * 28 + N_SHIFT * 36 + N_TRAP * 90 + 200;

    logic            clk, rstn;
    alu_op_e         alu_op;
    shift_op_e       shift_op;
    logic            unsigned_sel, opa_pc, opb_imm, cp_trig, trap;
    logic [XLEN-1:0] rs1, rs2, pc, imm, res, add_res;
    logic [1:0]      cmp;
    logic            exc, cp_done;
    int              checks, errors, mark_checks, mark_errors;
    bit              exc_seen;

    tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .rstn_o(rstn));

    alu_top alu_top_inst (
        .clk_i(clk), .rstn_i(rstn), .alu_op_i(alu_op), .shift_op_i(shift_op),
        .unsigned_i(unsigned_sel), .opa_pc_i(opa_pc), .opb_imm_i(opb_imm),
        .cp_trig_i(cp_trig), .trap_i(trap), .rs1_i(rs1), .rs2_i(rs2), .pc_i(pc),
        .imm_i(imm), .cmp_o(cmp), .res_o(res), .add_o(add_res), .exc_o(exc),
        .cp_done_o(cp_done)
    );

    // ----------------------------------------
    // timing and reporting helpers
    // ----------------------------------------
    task automatic drive_slot();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_word(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - mark_checks, errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic less_than(input logic [XLEN-1:0] a, b, input logic uns);
        return uns ? (a < b) : ($signed(a) < $signed(b));
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input alu_op_e op,
            input logic [XLEN-1:0] a, b, r1, input logic uns);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return XLEN'(less_than(a, b, uns)); // 0 or 1
            ALU_MOVB: return b;
            ALU_XOR:  return r1 ^ b;
            ALU_OR:   return r1 | b;
            ALU_AND:  return r1 & b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_shift(input shift_op_e op,
            input logic [XLEN-1:0] d, input logic [SHAMT_W-1:0] amt);
        case (op)
            SHIFT_SLL: return d << amt;
            SHIFT_SRL: return d >> amt;
            default:   return $signed(d) >>> amt; // sign fill
        endcase
    endfunction

    function automatic shift_op_e random_shift_op();
        case ($urandom_range(2, 0))
            0:       return SHIFT_SLL;
            1:       return SHIFT_SRL;
            default: return SHIFT_SRA;
        endcase
    endfunction

    // ----------------------------------------
    // co-processor sequences
    // ----------------------------------------
    task automatic run_shift(input shift_op_e op, input logic [XLEN-1:0] data,
                             input logic [SHAMT_W-1:0] amt);
        logic [XLEN-1:0] exp_res;
        int              cyc;
        bit              seen;
        exp_res = model_shift(op, data, amt);
        cyc = 0;
        seen = 1'b0;
        drive_slot();
        alu_op = ALU_CP;
        shift_op = op;
        rs1 = data;
        opb_imm = 1'b1;
        imm = ($urandom() & ~32'h1f) | XLEN'(amt); // upper bits must be ignored
        cp_trig = 1'b1;
        while (!seen && cyc < DONE_WAIT) begin
            drive_slot();
            cp_trig = 1'b0;
            cyc++;
            @(negedge clk);
            seen = cp_done;
            check_word("res_o cleared while running", res, '0);
        end
        if (!seen) begin
            errors++;
            $display("ERROR at %0t ns: no done pulse within %0d cycles of a shift trigger",
                     $time, DONE_WAIT);
        end else begin
            check_word("done latency in cycles", cyc, int'(amt) + 1);
            drive_slot();
            @(negedge clk);
            check_word("cp_done_o one cycle later", XLEN'(cp_done), '0);
            check_word("shift result", res, exp_res);
        end
        drive_slot(); // idle, lets the monitor close its run
    endtask

    task automatic run_trap();
        logic [SHAMT_W-1:0] amt;
        int                 lead;
        amt = SHAMT_W'($urandom_range(31, 20)); // long enough to interrupt
        lead = $urandom_range(10, 2);
        drive_slot();
        alu_op = ALU_CP;
        shift_op = random_shift_op();
        rs1 = $urandom();
        opb_imm = 1'b1;
        imm = XLEN'(amt);
        cp_trig = 1'b1;
        repeat (lead) begin
            drive_slot();
            cp_trig = 1'b0;
        end
        trap = 1'b1;
        drive_slot();
        trap = 1'b0;
        for (int k = 0; k < DONE_WAIT; k++) begin
            @(negedge clk);
            check_word("cp_done_o after trap", XLEN'(cp_done), '0);
            check_word("res_o after trap", res, '0); // never completed
            drive_slot();
        end
        run_shift(random_shift_op(), $urandom(), SHAMT_W'($urandom_range(31, 0)));
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : stimulus
        alu_op_e op;
        void'($urandom(5201));
        alu_op = ALU_CP;
        shift_op = SHIFT_SLL;
        {unsigned_sel, opa_pc, opb_imm, cp_trig, trap} = '0;
        {rs1, rs2, pc, imm} = '0;
        {checks, errors, mark_checks, mark_errors} = '0;
        wait (rstn === 1'b1);
        drive_slot();
        @(negedge clk);
        check_word("cp_done_o after reset", XLEN'(cp_done), '0);
        check_word("exc_o after reset", XLEN'(exc), '0);
        check_word("res_o under ALU_CP after reset", res, '0);
        finish_test(1, "reset state");
        for (int n = 0; n < N_CMP; n++) begin
            drive_slot();
            rs1 = $urandom();
            case ($urandom_range(3, 0))
                0:       rs2 = rs1;                    // equal
                1:       rs2 = rs1 ^ 32'h8000_0000;    // sign bit differs
                default: rs2 = $urandom();
            endcase
            unsigned_sel = n[0];
            @(negedge clk);
            check_word("cmp_o", XLEN'(cmp), XLEN'({less_than(rs1, rs2, unsigned_sel),
                       rs1 == rs2}));
        end
        finish_test(2, "comparator");
        for (int n = 0; n < N_ALU; n++) begin
            for (int m = 0; m < 4; m++) begin
                for (int k = 0; k < 8; k++) begin
                    op = alu_op_e'(k);
                    if (op != ALU_CP) begin
                        drive_slot();
                        {rs1, rs2, pc, imm} = {$urandom(), $urandom(), $urandom(), $urandom()};
                        alu_op = op;
                        opa_pc = m[0];
                        opb_imm = m[1];
                        unsigned_sel = n[0]; // slt both ways
                        @(negedge clk);
                        check_word("res_o", res, model_alu(op, opa_pc ? pc : rs1,
                                   opb_imm ? imm : rs2, rs1, unsigned_sel));
                        if (op == ALU_ADD || op == ALU_SUB || op == ALU_SLT) begin
                            check_word("add_o", add_res, model_alu(op == ALU_ADD ? ALU_ADD :
                                       ALU_SUB, opa_pc ? pc : rs1, opb_imm ? imm : rs2, rs1, 1'b0));
                        end
                    end
                end
            end
        end
        finish_test(3, "alu ops and operand muxes");
        for (int n = 0; n < N_SHIFT; n++) begin
            run_shift(random_shift_op(), $urandom(),
                      n == 0 ? 5'd0 : n == 1 ? 5'd31 : SHAMT_W'($urandom_range(31, 0)));
        end
        finish_test(4, "shifter");
        repeat (N_TRAP) run_trap();
        finish_test(5, "trap abort");
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end : stimulus

    always @(negedge clk) begin : exc_watch
        if (rstn && exc !== 1'b0 && !exc_seen) begin
            exc_seen = 1'b1;
            errors++;
            $display("CHECK FAILED at %0t ns: exc_o went high, expected low", $time);
        end
    end : exc_watch

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end : watchdog

endmodule

// ==== files.f ====
src/alu_pkg.sv
src/alu_prefix_adder.sv
src/alu_datapath.sv
src/alu_shifter.sv
src/alu_cp_unit.sv
src/alu_top.sv
dv/tb_clock_gen.sv
dv/alu_assertions.sv
dv/alu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the ALU testbench, verdict taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module alu_tb -f files.f -o alu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi
./obj_dir/alu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "^PASS: all tests$" sim.log; then
    echo "pass message missing from sim.log"
    exit 1
fi
exit 0
